// ==== rtl/panel_cfg.svh ====
`ifndef PANEL_CFG_SVH
`define PANEL_CFG_SVH

// the lockout runs for about 2**DBNCE_BITS cycles.
`define DBNCE_BITS 4

`define WORD_BITS 12
`define ADDR_BITS 12

// eight fields of 4K words each.
`define FIELD_BITS 3

`endif

// ==== rtl/machine_pkg.sv ====
`include "panel_cfg.svh"

package machine_pkg;

    typedef logic [`WORD_BITS-1:0] word_t;
    typedef logic [`ADDR_BITS-1:0] addr_t;
    typedef logic [`FIELD_BITS-1:0] field_t;

    // field in the high bits, address within the field below it.
    typedef logic [`FIELD_BITS+`ADDR_BITS-1:0] mem_addr_t;

    // reduced major states, one-hot coded.
    typedef enum logic [4:0]
    {
        H0 = 5'b00001,
        HW = 5'b00010,
        F0 = 5'b00100,
        D0 = 5'b01000,
        E0 = 5'b10000
    } major_state_t;

endpackage

// ==== rtl/panel_pkg.sv ====
package panel_pkg;

    typedef enum logic [2:0]
    {
        tr_latch    = 3'b110,
        tr_wait     = 3'b000,
        tr_trig1    = 3'b001,
        tr_trig2    = 3'b010,
        tr_trig3    = 3'b011,
        tr_delay    = 3'b100,
        tr_reenable = 3'b101
    } trig_state_t;

    // bit order is {clear, extd_addr, addr_load, dep, exam, cont}.
    typedef logic [5:0] panel_cmd_t;

endpackage

// ==== rtl/front_panel.sv ====
`include "panel_cfg.svh"

module front_panel
    import machine_pkg::*;
    import panel_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  major_state_t state,
    input  logic         clear,
    input  logic         extd_addr,
    input  logic         addr_load,
    input  logic         dep,
    input  logic         exam,
    input  logic         cont,
    input  logic         sing_step,
    input  logic         halt, // halt goes straight to the sequencer.
    output logic         triggerd,
    output logic         cleard,
    output logic         extd_addrd,
    output logic         addr_loadd,
    output logic         depd,
    output logic         examd,
    output logic         contd,
    output logic         sw_active
);

    trig_state_t          trig_state;
    panel_cmd_t           switch_latch;
    logic [6:0]           switch_held;
    logic [`DBNCE_BITS:0] trig_cnt;
    logic                 accept;

    assign {triggerd, cleard, extd_addrd, addr_loadd, depd, examd, contd} = switch_held;

    // a running machine only takes a single-step continue.
    always_comb
    begin
        case (state)
            H0, HW:     accept = 1'b1;
            F0, D0, E0: accept = switch_latch[0] & sing_step;
            default:    accept = 1'b0;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            trig_state   <= tr_latch;
            switch_latch <= '0;
            switch_held  <= '0;
            trig_cnt     <= '0;
            sw_active    <= 1'b0;
        end
        else
        begin
            case (trig_state)
                tr_latch:
                begin
                    switch_latch <= switch_latch | {clear, extd_addr, addr_load, dep, exam, cont};
                    if (switch_latch != '0)
                        trig_state <= tr_wait;
                end
                tr_wait:
                begin
                    if (accept)
                    begin
                        trig_state   <= tr_trig1;
                        switch_held  <= {1'b1, switch_latch};
                        switch_latch <= '0;
                    end
                end
                tr_trig1: trig_state <= tr_trig2;
                tr_trig2: trig_state <= tr_trig3;
                tr_trig3: trig_state <= tr_delay;
                tr_delay:
                begin
                    switch_held <= '0; // pulses end after the first delay cycle.
                    if (trig_cnt[`DBNCE_BITS])
                    begin
                        trig_state <= tr_reenable;
                        sw_active  <= 1'b0;
                    end
                    else
                        sw_active <= 1'b1;
                end
                tr_reenable: trig_state <= tr_latch;
                default:     trig_state <= tr_latch;
            endcase

            // the lockout is timed from the first trigger cycle.
            if (trig_state == tr_trig1)
                trig_cnt <= '0;
            else
                trig_cnt <= trig_cnt + 1'b1;
        end
    end

endmodule

// ==== rtl/panel_sequencer.sv ====
`include "panel_cfg.svh"

module panel_sequencer
    import machine_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  word_t        sr,
    input  logic         cleard,
    input  logic         extd_addrd,
    input  logic         addr_loadd,
    input  logic         depd,
    input  logic         examd,
    input  logic         contd,
    input  logic         sing_step,
    input  logic         halt,
    input  word_t        mem_rdata,
    output major_state_t state,
    output addr_t        pc,
    output field_t       field,
    output word_t        mb,
    output logic         run,
    output mem_addr_t    mem_addr,
    output word_t        mem_wdata,
    output logic         mem_we
);

    localparam int IND_BIT   = 8; // indirect bit of an instruction word.
    localparam int OFFS_BITS = 7; // page offset used by the defer read.

    logic [5:0] cmd_q;
    logic       clear_rise;
    logic       extd_rise;
    logic       load_rise;
    logic       dep_rise;
    logic       exam_rise;
    logic       cont_rise;
    logic       halted;
    logic       phase;
    logic       exam_pend;

    assign {clear_rise, extd_rise, load_rise, dep_rise, exam_rise, cont_rise} =
        {cleard, extd_addrd, addr_loadd, depd, examd, contd} & ~cmd_q;

    assign halted    = (state == H0) || (state == HW);
    assign mem_we    = halted & dep_rise & ~(clear_rise | extd_rise | load_rise);
    assign mem_wdata = sr;

    always_comb
    begin
        if (state == D0)
            mem_addr = {field, {(`ADDR_BITS-OFFS_BITS){1'b0}}, mb[OFFS_BITS-1:0]};
        else
            mem_addr = {field, pc};
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cmd_q     <= '0;
            state     <= H0;
            pc        <= '0;
            field     <= '0;
            mb        <= '0;
            run       <= 1'b0;
            phase     <= 1'b0;
            exam_pend <= 1'b0;
        end
        else
        begin
            cmd_q     <= {cleard, extd_addrd, addr_loadd, depd, examd, contd};
            exam_pend <= 1'b0;
            if (exam_pend)
                mb <= mem_rdata; // examine data arrives one cycle after the address.

            case (state)
                H0, HW:
                begin
                    if (clear_rise)
                    begin
                        pc    <= '0;
                        field <= '0;
                        mb    <= '0;
                        state <= H0;
                    end
                    else if (extd_rise)
                        field <= sr[`FIELD_BITS-1:0];
                    else if (load_rise)
                        pc <= sr[`ADDR_BITS-1:0];
                    else if (dep_rise)
                    begin
                        mb <= sr;
                        pc <= pc + 1'b1;
                    end
                    else if (exam_rise)
                    begin
                        pc        <= pc + 1'b1;
                        exam_pend <= 1'b1;
                    end
                    else if (cont_rise)
                    begin
                        state <= F0;
                        run   <= 1'b1;
                        phase <= 1'b0;
                    end
                end
                F0:
                begin
                    // first half addresses memory, second half takes the word.
                    if (!phase)
                    begin
                        pc    <= pc + 1'b1;
                        phase <= 1'b1;
                    end
                    else
                    begin
                        mb    <= mem_rdata;
                        phase <= 1'b0;
                        state <= mem_rdata[IND_BIT] ? D0 : E0;
                    end
                end
                D0:
                begin
                    if (!phase)
                        phase <= 1'b1;
                    else
                    begin
                        mb    <= mem_rdata;
                        phase <= 1'b0;
                        state <= E0;
                    end
                end
                E0:
                begin
                    if (halt || sing_step)
                    begin
                        state <= HW;
                        run   <= 1'b0;
                    end
                    else
                        state <= F0;
                end
                default: state <= H0;
            endcase
        end
    end

endmodule

// ==== rtl/core_memory.sv ====
`include "panel_cfg.svh"

module core_memory
    import machine_pkg::*;
(
    input  logic      clk,
    input  mem_addr_t addr,
    input  word_t     wdata,
    input  logic      we,
    output word_t     rdata
);

    localparam int DEPTH = 2 ** (`FIELD_BITS + `ADDR_BITS);

    word_t mem [0:DEPTH-1];

    // a read during a write to the same word returns the old contents.
    always_ff @(posedge clk)
    begin
        if (we)
            mem[addr] <= wdata;
        rdata <= mem[addr];
    end

endmodule

// ==== rtl/console_top.sv ====
module console_top
    import machine_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         clear,
    input  logic         extd_addr,
    input  logic         addr_load,
    input  logic         dep,
    input  logic         exam,
    input  logic         cont,
    input  logic         sing_step,
    input  logic         halt,
    input  word_t        sr,
    output addr_t        pc,
    output field_t       field,
    output word_t        mb,
    output major_state_t state,
    output logic         run,
    output logic         sw_active
);

    logic      cleard;
    logic      extd_addrd;
    logic      addr_loadd;
    logic      depd;
    logic      examd;
    logic      contd;
    mem_addr_t mem_addr;
    word_t     mem_wdata;
    word_t     mem_rdata;
    logic      mem_we;

    front_panel i_front_panel (
        .clk        (clk),
        .reset      (reset),
        .state      (state),
        .clear      (clear),
        .extd_addr  (extd_addr),
        .addr_load  (addr_load),
        .dep        (dep),
        .exam       (exam),
        .cont       (cont),
        .sing_step  (sing_step),
        .halt       (halt),
        .triggerd   (),
        .cleard     (cleard),
        .extd_addrd (extd_addrd),
        .addr_loadd (addr_loadd),
        .depd       (depd),
        .examd      (examd),
        .contd      (contd),
        .sw_active  (sw_active)
    );

    panel_sequencer i_panel_sequencer (
        .clk        (clk),
        .reset      (reset),
        .sr         (sr),
        .cleard     (cleard),
        .extd_addrd (extd_addrd),
        .addr_loadd (addr_loadd),
        .depd       (depd),
        .examd      (examd),
        .contd      (contd),
        .sing_step  (sing_step),
        .halt       (halt),
        .mem_rdata  (mem_rdata),
        .state      (state),
        .pc         (pc),
        .field      (field),
        .mb         (mb),
        .run        (run),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_we     (mem_we)
    );

    core_memory i_core_memory (
        .clk   (clk),
        .addr  (mem_addr),
        .wdata (mem_wdata),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

endmodule

// ==== verif/console_chk.sv ====
module console_chk
    import panel_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input trig_state_t trig_state,
    input logic        triggerd,
    input logic        cleard,
    input logic        extd_addrd,
    input logic        addr_loadd,
    input logic        depd,
    input logic        examd,
    input logic        contd,
    input logic        sw_active
);
    timeunit 1ns;
    timeprecision 1ps;

    int         fail_cnt = 0; // read by the testbench.
    logic [5:0] cmd_bits;

    assign cmd_bits = {cleard, extd_addrd, addr_loadd, depd, examd, contd};

    pulse_one_hot: assert property (@(posedge clk) disable iff (reset)
        triggerd |-> $onehot(cmd_bits))
    else
    begin
        fail_cnt++;
        $error("more or fewer than one command pulse is high");
    end

    pulse_length: assert property (@(posedge clk) disable iff (reset)
        $rose(triggerd) |-> triggerd [*4] ##1 !triggerd)
    else
    begin
        fail_cnt++;
        $error("command pulse did not last four cycles");
    end

    lockout_apart: assert property (@(posedge clk) disable iff (reset)
        !(sw_active && triggerd))
    else
    begin
        fail_cnt++;
        $error("sw_active is high during a command pulse");
    end

    pulse_in_window: assert property (@(posedge clk) disable iff (reset)
        triggerd |-> trig_state inside {tr_trig1, tr_trig2, tr_trig3, tr_delay})
    else
    begin
        fail_cnt++;
        $error("command pulse outside the trigger states");
    end

endmodule

// ==== verif/console_tb.sv ====
`include "panel_cfg.svh"

module console_tb
    import machine_pkg::*;
    import panel_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam panel_cmd_t CMD_CLEAR = 6'b100000;
    localparam panel_cmd_t CMD_EXTD  = 6'b010000;
    localparam panel_cmd_t CMD_LOAD  = 6'b001000;
    localparam panel_cmd_t CMD_DEP   = 6'b000100;
    localparam panel_cmd_t CMD_EXAM  = 6'b000010;
    localparam panel_cmd_t CMD_CONT  = 6'b000001;

    localparam addr_t RUN_BASE  = 12'h200;
    localparam int    RUN_WORDS = 24; // far more words than the free run reaches.
    localparam int    N_CMDS    = 65; // presses issued by the whole sequence.
    localparam int    WATCHDOG_CYCLES = N_CMDS * ((2 ** `DBNCE_BITS) + 20) + 200;

    logic         clk;
    logic         reset;
    logic         clear;
    logic         extd_addr;
    logic         addr_load;
    logic         dep;
    logic         exam;
    logic         cont;
    logic         sing_step;
    logic         halt;
    word_t        sr;
    addr_t        pc;
    field_t       field;
    word_t        mb;
    major_state_t state;
    logic         run;
    logic         sw_active;

    int           seed = 32'h2abd_db70;
    addr_t        m_pc;
    field_t       m_field;
    word_t        m_mb;
    major_state_t m_state;
    word_t        model_mem [mem_addr_t];
    event         check_ev;

    console_top i_console_top (
        .clk       (clk),
        .reset     (reset),
        .clear     (clear),
        .extd_addr (extd_addr),
        .addr_load (addr_load),
        .dep       (dep),
        .exam      (exam),
        .cont      (cont),
        .sing_step (sing_step),
        .halt      (halt),
        .sr        (sr),
        .pc        (pc),
        .field     (field),
        .mb        (mb),
        .state     (state),
        .run       (run),
        .sw_active (sw_active)
    );

    bind front_panel console_chk i_console_chk (
        .clk        (clk),
        .reset      (reset),
        .trig_state (trig_state),
        .triggerd   (triggerd),
        .cleard     (cleard),
        .extd_addrd (extd_addrd),
        .addr_loadd (addr_loadd),
        .depd       (depd),
        .examd      (examd),
        .contd      (contd),
        .sw_active  (sw_active)
    );

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    // reference model of the console registers and memory.
    function automatic void model_cmd(panel_cmd_t cmd, word_t sw);
        word_t word;
        if (cmd[5])
        begin
            m_pc    = '0;
            m_field = '0;
            m_mb    = '0;
            m_state = H0;
        end
        else if (cmd[4])
            m_field = sw[`FIELD_BITS-1:0];
        else if (cmd[3])
            m_pc = sw;
        else if (cmd[2])
        begin
            model_mem[{m_field, m_pc}] = sw;
            m_mb = sw;
            m_pc = m_pc + 1'b1;
        end
        else if (cmd[1])
        begin
            m_mb = model_mem[{m_field, m_pc}];
            m_pc = m_pc + 1'b1;
        end
        else if (cmd[0])
        begin
            word = model_mem[{m_field, m_pc}]; // one instruction under single step.
            m_pc = m_pc + 1'b1;
            m_mb = word[8] ? model_mem[{m_field, 5'b00000, word[6:0]}] : word;
            m_state = HW;
        end
    endfunction

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
        $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, want);
        $display("CHECKS FAILED");
        $fatal(1, "value mismatch on %s", name);
    endtask

    task automatic report_failure(string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "%s", what);
    endtask

    task automatic press_cmd(panel_cmd_t cmd, word_t value);
        @(negedge clk);
        sr = value;
        {clear, extd_addr, addr_load, dep, exam, cont} = cmd;
        @(negedge clk);
        {clear, extd_addr, addr_load, dep, exam, cont} = '0;
    endtask

    task automatic wait_settle();
        int low_cnt;
        int high_cnt;
        while (!sw_active)
            @(negedge clk);
        high_cnt = 0;
        while (sw_active)
        begin
            high_cnt++;
            @(negedge clk);
        end
        // the lockout lasts about 2**DBNCE_BITS cycles.
        assert (high_cnt >= (2 ** `DBNCE_BITS) / 2 && high_cnt <= (2 ** `DBNCE_BITS))
        else
            report_failure($sformatf("sw_active lockout lasted %0d cycles", high_cnt));
        low_cnt = 1;
        while (low_cnt < 2)
        begin
            @(negedge clk);
            low_cnt = sw_active ? 0 : low_cnt + 1;
        end
    endtask

    task automatic do_cmd(panel_cmd_t cmd, word_t value);
        press_cmd(cmd, value);
        model_cmd(cmd, value);
        wait_settle();
        -> check_ev;
    endtask

    task automatic deposit_block(field_t f, addr_t start, int count, word_t keep);
        int i;
        do_cmd(CMD_EXTD, word_t'(f));
        do_cmd(CMD_LOAD, start);
        for (i = 0; i < count; i++)
            do_cmd(CMD_DEP, rand_word() & keep);
    endtask

    task automatic examine_block(field_t f, addr_t start, int count);
        int i;
        do_cmd(CMD_EXTD, word_t'(f));
        do_cmd(CMD_LOAD, start);
        for (i = 0; i < count; i++)
            do_cmd(CMD_EXAM, start);
    endtask

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial
    begin
        forever
        begin
            @(check_ev);
            assert (pc == m_pc) else report_mismatch("pc", pc, m_pc);
            assert (field == m_field) else report_mismatch("field", field, m_field);
            assert (mb == m_mb) else report_mismatch("mb", mb, m_mb);
            assert (state == m_state) else report_mismatch("state", state, m_state);
            assert (run == 1'b0) else report_mismatch("run", run, 0);
        end
    end

    initial
    begin
        wait (i_console_top.i_front_panel.i_console_chk.fail_cnt != 0);
        report_failure("an assertion on the front panel pulses failed");
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure($sformatf("timeout after %0d cycles", WATCHDOG_CYCLES));
    end

    initial
    begin
        word_t val;
        addr_t base;
        addr_t run_len;
        addr_t last_pc;

        reset     = 1'b1;
        {clear, extd_addr, addr_load, dep, exam, cont} = '0;
        sing_step = 1'b0;
        halt      = 1'b0;
        sr        = '0;
        m_pc      = '0;
        m_field   = '0;
        m_mb      = '0;
        m_state   = H0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        -> check_ev;

        do_cmd(CMD_LOAD, rand_word());
        do_cmd(CMD_EXTD, rand_word());

        base = rand_word(); // same addresses in two fields.
        deposit_block(field_t'(2), base, 4, 12'hfff);
        deposit_block(field_t'(5), base, 4, 12'hfff);
        examine_block(field_t'(2), base, 4);
        examine_block(field_t'(5), base, 4);

        do_cmd(CMD_CLEAR, rand_word());

        val = rand_word();
        press_cmd(CMD_LOAD, val);
        model_cmd(CMD_LOAD, val);
        while (!sw_active)
            @(negedge clk);
        press_cmd(CMD_DEP, ~val); // lost in the lockout.
        wait_settle();
        -> check_ev;

        sing_step = 1'b1;
        do_cmd(CMD_LOAD, 12'h020);
        do_cmd(CMD_DEP, rand_word());
        do_cmd(CMD_LOAD, 12'h100);
        do_cmd(CMD_DEP, rand_word() & 12'heff);
        do_cmd(CMD_DEP, (rand_word() & 12'he80) | 12'h120); // defers to word 0x020.
        do_cmd(CMD_LOAD, 12'h100);
        do_cmd(CMD_CONT, '0);
        do_cmd(CMD_CONT, '0);

        sing_step = 1'b0;
        deposit_block(field_t'(0), RUN_BASE, RUN_WORDS, 12'heff);
        do_cmd(CMD_LOAD, RUN_BASE);
        press_cmd(CMD_CONT, '0);
        wait_settle();
        assert (run == 1'b1) else report_mismatch("run", run, 1);
        assert (pc != RUN_BASE) else report_failure("pc did not advance while running");

        halt = 1'b1;
        while (state != HW)
            @(negedge clk);
        run_len = pc - RUN_BASE;
        last_pc = pc - 1'b1;
        assert (run == 1'b0) else report_mismatch("run", run, 0);
        assert (run_len >= 1 && run_len <= RUN_WORDS)
        else
            report_failure("pc left the deposited block while running");
        assert (mb == model_mem[{3'd0, last_pc}])
        else
            report_mismatch("mb", mb, model_mem[{3'd0, last_pc}]);

        @(negedge clk);
        if (i_console_top.i_front_panel.i_console_chk.fail_cnt == 0)
        begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
        else
            report_failure("an assertion on the front panel pulses failed");
    end

endmodule

// ==== console.f ====
+incdir+rtl
rtl/machine_pkg.sv
rtl/panel_pkg.sv
rtl/front_panel.sv
rtl/panel_sequencer.sv
rtl/core_memory.sv
rtl/console_top.sv
verif/console_chk.sv
verif/console_tb.sv

// ==== Bender.yml ====
package:
  name: console

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/machine_pkg.sv
      - rtl/panel_pkg.sv
      - rtl/front_panel.sv
      - rtl/panel_sequencer.sv
      - rtl/core_memory.sv
      - rtl/console_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - verif/console_chk.sv
      - verif/console_tb.sv
